/* design/decode_stage.sv */
// Decode stage that fills the ID/EX register from IF/ID and holds the register file
module decode_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  word_t     if_pc_i,
    input  word_t     if_instr_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_rd_i,
    input  word_t     wb_data_i,
    input  logic      branch_taken_i,
    output logic      load_stall_o,
    id_ex_if.src      id_ex
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      regs [32];
    word_t      rs1_data;
    word_t      rs2_data;

    // Decoded controls before the ID/EX register
    word_t      imm_d;
    alu_op_e    alu_op_d;
    logic       use_imm_d;
    logic       is_branch_d;
    logic       branch_ne_d;
    logic       mem_read_d;
    logic       mem_write_d;
    logic       reg_write_d;

    assign opcode = if_instr_i[6:0];
    assign rd     = if_instr_i[11:7];
    assign funct3 = if_instr_i[14:12];
    assign rs1    = if_instr_i[19:15];
    assign rs2    = if_instr_i[24:20];
    assign funct7 = if_instr_i[31:25];

    assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
    assign imm_s = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
    assign imm_b = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                    if_instr_i[30:25], if_instr_i[11:8], 1'b0};

    //////////////////////////////////////////////////////////////////////
    // Instruction decode
    //////////////////////////////////////////////////////////////////////

    // Anything not recognised leaves every control bit low
    always_comb begin
        imm_d       = imm_i;
        alu_op_d    = ALU_ADD;
        use_imm_d   = 1'b0;
        is_branch_d = 1'b0;
        branch_ne_d = 1'b0;
        mem_read_d  = 1'b0;
        mem_write_d = 1'b0;
        reg_write_d = 1'b0;
        case (opcode)
            OPC_OP: begin
                reg_write_d = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op_d = ALU_ADD;
                    {7'h20, 3'b000}: alu_op_d = ALU_SUB;
                    {7'h00, 3'b111}: alu_op_d = ALU_AND;
                    {7'h00, 3'b110}: alu_op_d = ALU_OR;
                    {7'h00, 3'b100}: alu_op_d = ALU_XOR;
                    {7'h00, 3'b010}: alu_op_d = ALU_SLT;
                    default:         reg_write_d = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // ADDI only
                use_imm_d   = 1'b1;
                reg_write_d = (funct3 == 3'b000);
            end
            OPC_LOAD: begin
                use_imm_d   = 1'b1;
                mem_read_d  = (funct3 == 3'b010);
                reg_write_d = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                imm_d       = imm_s;
                use_imm_d   = 1'b1;
                mem_write_d = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                imm_d       = imm_b;
                is_branch_d = (funct3 == 3'b000) || (funct3 == 3'b001);
                branch_ne_d = funct3[0];
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wb_we_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // Write-through so a same-cycle writeback is seen here
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wb_we_i && wb_rd_i == rs1) ? wb_data_i : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wb_we_i && wb_rd_i == rs2) ? wb_data_i : regs[rs2];

    // Load in EX whose result the instruction in ID needs
    assign load_stall_o = id_ex.mem_read && (id_ex.rd_addr != '0) &&
                          ((id_ex.rd_addr == rs1) || (id_ex.rd_addr == rs2));

    //////////////////////////////////////////////////////////////////////
    // ID/EX register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_ex.is_branch <= 1'b0;
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
            id_ex.reg_write <= 1'b0;
        end else if (load_stall_o || branch_taken_i) begin
            // Bubble for a load-use hold or a taken branch
            id_ex.is_branch <= 1'b0;
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
            id_ex.reg_write <= 1'b0;
        end else begin
            id_ex.is_branch <= is_branch_d;
            id_ex.mem_read  <= mem_read_d;
            id_ex.mem_write <= mem_write_d;
            id_ex.reg_write <= reg_write_d;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.pc        <= if_pc_i;
        id_ex.rs1_data  <= rs1_data;
        id_ex.rs2_data  <= rs2_data;
        id_ex.rs1_addr  <= rs1;
        id_ex.rs2_addr  <= rs2;
        id_ex.rd_addr   <= rd;
        id_ex.imm       <= imm_d;
        id_ex.alu_op    <= alu_op_d;
        id_ex.use_imm   <= use_imm_d;
        id_ex.branch_ne <= branch_ne_d;
    end

endmodule

/* design/execute_stage.sv */
// Execute stage that forwards operands, runs the ALU and resolves branches into EX/MEM
module execute_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    id_ex_if.dst      id_ex,
    input  logic      wb_we_i,
    input  reg_addr_t wb_rd_i,
    input  word_t     wb_data_i,
    output logic      branch_taken_o,
    output word_t     branch_target_o,
    ex_mem_if.src     ex_mem
);

    word_t op_a;
    word_t rs2_fwd;
    word_t op_b;
    word_t alu_result;
    logic  operands_eq;

    //////////////////////////////////////////////////////////////////////
    // Forwarding
    //////////////////////////////////////////////////////////////////////

    // EX/MEM is newer than MEM/WB and is checked last so it wins
    function automatic word_t forward(input reg_addr_t addr, input word_t reg_val);
        word_t val;
        val = reg_val;
        if (wb_we_i && wb_rd_i != '0 && wb_rd_i == addr) begin
            val = wb_data_i;
        end
        if (ex_mem.reg_write && ex_mem.rd_addr != '0 && ex_mem.rd_addr == addr) begin
            val = ex_mem.alu_result;
        end
        return val;
    endfunction

    always_comb begin
        op_a    = forward(id_ex.rs1_addr, id_ex.rs1_data);
        rs2_fwd = forward(id_ex.rs2_addr, id_ex.rs2_data);
    end

    assign op_b = id_ex.use_imm ? id_ex.imm : rs2_fwd;

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_result = op_a + op_b;
        endcase
    end

    // Branch compare uses the forwarded register values and not the immediate
    assign operands_eq     = (op_a == rs2_fwd);
    assign branch_taken_o  = id_ex.is_branch && (id_ex.branch_ne ? !operands_eq : operands_eq);
    assign branch_target_o = id_ex.pc + id_ex.imm;

    //////////////////////////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.reg_write <= 1'b0;
        end else begin
            ex_mem.mem_read  <= id_ex.mem_read;
            ex_mem.mem_write <= id_ex.mem_write;
            ex_mem.reg_write <= id_ex.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= rs2_fwd;
        ex_mem.rd_addr    <= id_ex.rd_addr;
    end

endmodule

/* design/fetch_stage.sv */
// Fetch stage that holds the PC and the IF/ID register, instantiated by the core top level
module fetch_stage import rv_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  load_stall_i,
    input  logic  branch_taken_i,
    input  word_t branch_target_i,
    output word_t imem_addr_o,
    input  word_t imem_rdata_i,
    output word_t if_pc_o,
    output word_t if_instr_o
);

    word_t pc_q;

    // Instruction memory answers combinationally on the current PC
    assign imem_addr_o = pc_q;

    //////////////////////////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////////////////////////

    // Redirect has priority over the load-use hold
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (branch_taken_i) begin
            pc_q <= branch_target_i;
        end else if (!load_stall_i) begin
            pc_q <= pc_q + word_t'(4);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // IF/ID register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_instr_o <= NOP_INSTR;
        end else if (branch_taken_i) begin
            if_instr_o <= NOP_INSTR;
        end else if (!load_stall_i) begin
            if_instr_o <= imem_rdata_i;
        end
    end

    // PC that travels with the instruction in IF/ID
    always_ff @(posedge clk) begin
        if (!load_stall_i) begin
            if_pc_o <= pc_q;
        end
    end

endmodule

/* design/mem_wb_stage.sv */
// Memory and writeback stage that drives the data memory port and returns results to decode
module mem_wb_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    ex_mem_if.dst     ex_mem,
    output word_t     dmem_addr_o,
    output word_t     dmem_wdata_o,
    output logic      dmem_we_o,
    output logic      dmem_re_o,
    input  word_t     dmem_rdata_i,
    output logic      wb_we_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    word_t result_d;

    //////////////////////////////////////////////////////////////////////
    // Data memory port
    //////////////////////////////////////////////////////////////////////

    // A word store lands in memory on the next rising edge
    assign dmem_addr_o  = ex_mem.alu_result;
    assign dmem_wdata_o = ex_mem.store_data;
    assign dmem_we_o    = ex_mem.mem_write;
    assign dmem_re_o    = ex_mem.mem_read;

    // Load data or ALU result is picked before the register
    assign result_d = ex_mem.mem_read ? dmem_rdata_i : ex_mem.alu_result;

    //////////////////////////////////////////////////////////////////////
    // MEM/WB register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= ex_mem.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= ex_mem.rd_addr;
        wb_data_o <= result_d;
    end

endmodule

/* design/rv_core.sv */
// Top level of the five-stage RV32I core with both memories attached outside on plain ports
module rv_core import rv_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst,
    output word_t imem_addr_o,
    input  word_t imem_rdata_i,
    output word_t dmem_addr_o,
    output word_t dmem_wdata_o,
    output logic  dmem_we_o,
    output logic  dmem_re_o,
    input  word_t dmem_rdata_i
);

    word_t     if_pc;
    word_t     if_instr;
    logic      load_stall;
    logic      branch_taken;
    word_t     branch_target;

    // Writeback from MEM/WB
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    id_ex_if  id_ex_bus ();
    ex_mem_if ex_mem_bus ();

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_inst (
        .clk             (clk),
        .rst             (rst),
        .load_stall_i    (load_stall),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .imem_addr_o     (imem_addr_o),
        .imem_rdata_i    (imem_rdata_i),
        .if_pc_o         (if_pc),
        .if_instr_o      (if_instr)
    );

    decode_stage decode_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .if_pc_i        (if_pc),
        .if_instr_i     (if_instr),
        .wb_we_i        (wb_we),
        .wb_rd_i        (wb_rd),
        .wb_data_i      (wb_data),
        .branch_taken_i (branch_taken),
        .load_stall_o   (load_stall),
        .id_ex          (id_ex_bus.src)
    );

    execute_stage execute_stage_inst (
        .clk             (clk),
        .rst             (rst),
        .id_ex           (id_ex_bus.dst),
        .wb_we_i         (wb_we),
        .wb_rd_i         (wb_rd),
        .wb_data_i       (wb_data),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .ex_mem          (ex_mem_bus.src)
    );

    mem_wb_stage mem_wb_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .ex_mem       (ex_mem_bus.dst),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_re_o    (dmem_re_o),
        .dmem_rdata_i (dmem_rdata_i),
        .wb_we_o      (wb_we),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data)
    );

endmodule

/* design/rv_pkg.sv */
// Widths, types and encodings of the RV32I core that every RTL module imports
package rv_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and basic types
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN = 32;

    // Data, address and instruction word
    typedef logic [XLEN-1:0] word_t;

    // Register index from x0 to x31
    typedef logic [4:0] reg_addr_t;

    // ALU functions left in the reduced instruction set
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // Major opcodes
    //////////////////////////////////////////////////////////////////////

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // ADDI x0, x0, 0 fills every flushed slot
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

/* design/stage_if.sv */
// Interfaces that carry the registered ID/EX and EX/MEM bundles between the pipeline stages

// Registered ID/EX values that decode drives and execute consumes
interface id_ex_if import rv_pkg::*; ();

    word_t     pc;
    word_t     rs1_data;
    word_t     rs2_data;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    word_t     imm;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      is_branch;
    logic      branch_ne;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;

    modport src (
        output pc, rs1_data, rs2_data, rs1_addr, rs2_addr, rd_addr, imm,
        output alu_op, use_imm, is_branch, branch_ne, mem_read, mem_write, reg_write
    );

    modport dst (
        input pc, rs1_data, rs2_data, rs1_addr, rs2_addr, rd_addr, imm,
        input alu_op, use_imm, is_branch, branch_ne, mem_read, mem_write, reg_write
    );

endinterface

// Registered EX/MEM values that execute drives and memory/writeback consumes
interface ex_mem_if import rv_pkg::*; ();

    word_t     alu_result;
    word_t     store_data;
    reg_addr_t rd_addr;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;

    modport src (output alu_result, store_data, rd_addr, mem_read, mem_write, reg_write);
    modport dst (input alu_result, store_data, rd_addr, mem_read, mem_write, reg_write);

endinterface

/* dv/rv_core_tb.sv */
// Directed testbench that runs small programs on the RV32I core and checks every store
module rv_core_tb import rv_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    NUM_TESTS   = 5;
    localparam int    TEST_CYCLES = 200;
    localparam word_t END_ADDR    = 32'h3FC;
    localparam word_t IDLE_RDATA  = 32'hDEAD_C0DE;

    logic  clk;
    logic  por_rst;
    logic  hold_rst;
    logic  rst;
    word_t imem_addr;
    word_t imem_rdata;
    word_t dmem_addr;
    word_t dmem_wdata;
    word_t dmem_rdata;
    logic  dmem_we;
    logic  dmem_re;
    logic  end_seen;
    word_t imem [256];
    word_t dmem [256];
    word_t log_addr[$];
    word_t log_data[$];
    word_t exp_addr[$];
    word_t exp_data[$];
    word_t prog[$];
    word_t ref_regs [32];
    word_t ref_mem [word_t];
    word_t rng;
    int    error_count;
    int    tests_run;
    int    tests_passed;

    assign rst        = por_rst | hold_rst;
    assign imem_rdata = imem[imem_addr[9:2]];
    // Read data is only valid while dmem_re_o is high
    assign dmem_rdata = dmem_re ? dmem[dmem_addr[9:2]] : IDLE_RDATA;

    tb_clock_gen clock_gen_inst (.clk_o(clk), .rst_o(por_rst));

    rv_core #(
        .RESET_PC ('0)
    ) rv_core_inst (
        .clk          (clk),
        .rst          (rst),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_we_o    (dmem_we),
        .dmem_re_o    (dmem_re),
        .dmem_rdata_i (dmem_rdata)
    );

    // Data memory write and store log
    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
            log_addr.push_back(dmem_addr);
            log_data.push_back(dmem_wdata);
            if (dmem_addr == END_ADDR) begin
                end_seen <= 1'b1;
            end
        end
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * 10);
        $display("Watchdog expired after %0d cycles", NUM_TESTS * TEST_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Encoders and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic word_t xorshift32(input word_t x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic word_t r_word(input alu_op_e op, input reg_addr_t rd, rs1, rs2);
        logic [2:0] f3;
        case (op)
            ALU_AND: f3 = 3'b111;
            ALU_OR:  f3 = 3'b110;
            ALU_XOR: f3 = 3'b100;
            ALU_SLT: f3 = 3'b010;
            default: f3 = 3'b000;
        endcase
        return {(op == ALU_SUB) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_word(input logic [6:0] opc, input logic [2:0] f3,
                                     input reg_addr_t rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_word(input reg_addr_t rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_word(input logic [2:0] f3, input reg_addr_t rs1, rs2,
                                     input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    // RV32I arithmetic where SLT compares as signed
    function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return a + b;
        endcase
    endfunction

    task automatic set_ref(input reg_addr_t rd, input word_t value);
        if (rd != '0) begin
            ref_regs[rd] = value;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Program builders that keep the reference model in step
    //////////////////////////////////////////////////////////////////////

    task automatic addi_instr(input reg_addr_t rd, rs1, input logic [11:0] imm);
        prog.push_back(i_word(OPC_OP_IMM, 3'b000, rd, rs1, imm));
        set_ref(rd, ref_regs[rs1] + {{20{imm[11]}}, imm});
    endtask

    task automatic alu_instr(input alu_op_e op, input reg_addr_t rd, rs1, rs2);
        prog.push_back(r_word(op, rd, rs1, rs2));
        set_ref(rd, alu_ref(op, ref_regs[rs1], ref_regs[rs2]));
    endtask

    // Stores use x0 as base and a dead store stays out of the expected log
    task automatic store_instr(input reg_addr_t rs2, input logic [11:0] addr, input bit live);
        prog.push_back(s_word(rs2, 5'd0, addr));
        if (live) begin
            exp_addr.push_back(word_t'(addr));
            exp_data.push_back(ref_regs[rs2]);
            ref_mem[word_t'(addr)] = ref_regs[rs2];
        end
    endtask

    task automatic load_instr(input reg_addr_t rd, input logic [11:0] addr);
        word_t a;
        a = word_t'(addr);
        prog.push_back(i_word(OPC_LOAD, 3'b010, rd, 5'd0, addr));
        set_ref(rd, ref_mem.exists(a) ? ref_mem[a] : '0);
    endtask

    // Branch over two stores of x5 and x6
    task automatic branch_instr(input bit ne, input reg_addr_t rs1, rs2,
                                input logic [11:0] a0, a1);
        bit taken;
        taken = (ref_regs[rs1] == ref_regs[rs2]) ^ ne;
        prog.push_back(b_word({2'b00, ne}, rs1, rs2, 13'd12));
        store_instr(5, a0, !taken);
        store_instr(6, a1, !taken);
    endtask

    task automatic clear_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        ref_mem.delete();
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checking and test sequencing
    //////////////////////////////////////////////////////////////////////

    task automatic check_eq(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_reset_outputs();
        check_eq("imem_addr_o around reset", imem_addr, '0);
        check_eq("dmem_we_o around reset", word_t'(dmem_we), '0);
        check_eq("dmem_re_o around reset", word_t'(dmem_re), '0);
    endtask

    // Hold reset for two cycles while the memories load and wait for the end store
    task automatic run_program();
        int cycles;
        @(posedge clk);
        hold_rst <= 1'b1;
        @(negedge clk);
        check_reset_outputs();
        log_addr.delete();
        log_data.delete();
        end_seen = 1'b0;
        @(posedge clk);
        for (int i = 0; i < 256; i++) begin
            imem[i] <= (i < prog.size()) ? prog[i] : NOP_INSTR;
            dmem[i] <= '0;
        end
        @(negedge clk);
        check_reset_outputs();
        @(posedge clk);
        hold_rst <= 1'b0;
        @(negedge clk);
        check_reset_outputs();
        cycles = 0;
        while (!end_seen && cycles < TEST_CYCLES - 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!end_seen) begin
            $display("No store to address %h within %0d cycles", END_ADDR, cycles);
            error_count++;
        end
    endtask

    task automatic execute_test(input string name);
        int errs;
        errs = error_count;
        // End store followed by a branch to itself
        store_instr(0, 12'h3FC, 1'b1);
        prog.push_back(b_word(3'b000, 5'd0, 5'd0, 13'd0));
        run_program();
        check_eq("store count", log_addr.size(), exp_addr.size());
        for (int i = 0; i < log_addr.size() && i < exp_addr.size(); i++) begin
            check_eq($sformatf("store %0d address", i), log_addr[i], exp_addr[i]);
            check_eq($sformatf("store %0d data", i), log_data[i], exp_data[i]);
        end
        tests_run++;
        if (error_count == errs) begin
            tests_passed++;
            $display("%-14s ok", name);
        end else begin
            $display("%-14s FAILED with %0d errors", name, error_count - errs);
        end
    endtask

    task automatic dependency_chain();
        clear_program();
        addi_instr(1, 0, 12'd5);
        addi_instr(2, 1, 12'hFF4);
        alu_instr(ALU_ADD, 3, 2, 1);
        alu_instr(ALU_SUB, 4, 3, 1);
        alu_instr(ALU_XOR, 5, 4, 2);
        alu_instr(ALU_AND, 6, 5, 3);
        alu_instr(ALU_OR, 7, 6, 4);
        alu_instr(ALU_SLT, 8, 4, 7);
        alu_instr(ALU_SLT, 9, 2, 1);
        store_instr(9, 12'h020, 1'b1);
        for (int r = 1; r <= 8; r++) begin
            store_instr(reg_addr_t'(r), 12'(4 * r - 4), 1'b1);
        end
        execute_test("dependencies");
    endtask

    task automatic load_use();
        clear_program();
        rng = xorshift32(rng);
        addi_instr(1, 0, rng[11:0]);
        addi_instr(4, 0, rng[23:12]);
        store_instr(1, 12'h100, 1'b1);
        load_instr(2, 12'h100);
        alu_instr(ALU_ADD, 3, 2, 4);
        store_instr(3, 12'h104, 1'b1);
        // Dependent store data right behind a load
        load_instr(5, 12'h100);
        store_instr(5, 12'h108, 1'b1);
        execute_test("load-use");
    endtask

    task automatic branch_shadow();
        clear_program();
        addi_instr(1, 0, 12'd7);
        addi_instr(2, 0, 12'd7);
        addi_instr(3, 0, 12'd9);
        addi_instr(5, 0, 12'h055);
        addi_instr(6, 0, 12'h066);
        branch_instr(1'b0, 1, 2, 12'h300, 12'h304);
        branch_instr(1'b0, 1, 3, 12'h308, 12'h30C);
        branch_instr(1'b1, 1, 3, 12'h310, 12'h314);
        addi_instr(4, 1, 12'd0);
        branch_instr(1'b1, 4, 2, 12'h318, 12'h31C);
        execute_test("branches");
    endtask

    task automatic random_ops();
        clear_program();
        for (int i = 0; i < 20; i++) begin
            rng = xorshift32(rng);
            addi_instr(1, 0, rng[11:0]);
            addi_instr(2, 0, rng[23:12]);
            alu_instr(alu_op_e'(rng[26:24] % 6), reg_addr_t'(rng[29:27]), 1, 2);
            store_instr(reg_addr_t'(rng[29:27]), 12'h200 + 12'(4 * i), 1'b1);
        end
        execute_test("random ops");
    endtask

    initial begin
        hold_rst     = 1'b0;
        end_seen     = 1'b0;
        rng          = 32'h8d1c_8413;
        error_count  = 0;
        tests_run    = 0;
        tests_passed = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = NOP_INSTR;
            dmem[i] = '0;
        end
        clear_program();
        execute_test("reset");
        dependency_chain();
        load_use();
        branch_shadow();
        random_ops();
        $display("%0d of %0d tests ok, %0d failed checks", tests_passed, tests_run, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* dv/tb_clock_gen.sv */
// Clock and power-on reset source that the core testbench instantiates once
module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Held for the first two rising edges
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

/* files.f */
design/rv_pkg.sv
design/stage_if.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/rv_core.sv
dv/tb_clock_gen.sv
dv/rv_core_tb.sv
